// File: run.sh
#!/usr/bin/env bash
# build and run the execute cluster testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module ex_cluster_tb -Mdir "$build" -o ex_cluster_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build/ex_cluster_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
exit 0

// File: src.f
verilog/ex_pkg.sv
verilog/lane_if.sv
verilog/alu.sv
verilog/issue_decode.sv
verilog/ex_lane.sv
verilog/branch_resolve.sv
verilog/ex_cluster.sv
tb/ex_cluster_checker.sv
tb/ex_cluster_tb.sv

// File: tb/ex_cluster_checker.sv
// execute cluster output checker
`timescale 1ns/10ps

module ex_cluster_checker import ex_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic [num_lanes-1:0] in_valid,
  input logic [num_lanes-1:0] lane_valid,     // resolver inputs, one cycle before the outputs
  input logic [num_lanes-1:0] lane_take,
  input logic [num_lanes-1:0] lane_halt,
  input logic [num_lanes-1:0] out_valid,
  input logic                 redirect_valid,
  input logic                 out_halt
);

  int unsigned          fail_count = 0;   // failed assertions so far
  logic [num_lanes-1:0] decide;           // valid slots with a taken branch or halt
  logic [num_lanes-1:0] oldest;           // lowest deciding slot, one-hot
  logic [num_lanes-1:0] younger;          // slots above the oldest deciding one

  assign decide  = lane_valid & (lane_take | lane_halt);
  assign oldest  = decide & (~decide + 1'b1);      // isolate the lowest set bit
  assign younger = ~(oldest | (oldest - 1'b1));    // empty when nothing decides

  //////////////////////////////////////////////////////////////////////
  // output timing and squash rules
  //////////////////////////////////////////////////////////////////////

  // pipeline comes out of reset empty
  a_reset_quiet: assert property (@(posedge clock)
    $past(reset) |-> (out_valid == '0) && !redirect_valid && !out_halt)
    else begin
      fail_count++;
      $error("output active in the cycle after reset");
    end

  a_one_redirect: assert property (@(posedge clock) disable iff (reset)
    !(redirect_valid && out_halt))        // one slot decides the bundle
    else begin
      fail_count++;
      $error("redirect and halt raised together");
    end

  // kept slots are the bundle's valid slots up to the deciding one
  a_no_younger: assert property (@(posedge clock) disable iff (reset)
    (redirect_valid || out_halt) |->
      (out_valid != '0) && (out_valid == ($past(in_valid, 3) & ~$past(younger))))
    else begin
      fail_count++;
      $error("valid slot younger than the redirect or halt slot");
    end

  a_latency: assert property (@(posedge clock) disable iff (reset)
    !(redirect_valid || out_halt) |-> out_valid == $past(in_valid, 3))
    else begin
      fail_count++;
      $error("out_valid differs from in_valid three cycles back");
    end

endmodule

bind ex_cluster ex_cluster_checker chk_i (
  .clock          (clock),
  .reset          (reset),
  .in_valid       (in_valid),
  .lane_valid     (u_resolve.vld),
  .lane_take      (u_resolve.tkb),
  .lane_halt      (u_resolve.hlt),
  .out_valid      (out_valid),
  .redirect_valid (redirect_valid),
  .out_halt       (out_halt)
);

// File: tb/ex_cluster_tb.sv
// execute cluster testbench
`timescale 1ns/10ps

module ex_cluster_tb import ex_pkg::*; ();

  localparam int n_rand  = 120;                        // random operate bundles
  localparam int n_funcs = 17;
  localparam int n_total = n_rand + 6 + 32 + 12 + 8 + 3;  // every bundle sent

  logic                       clock = 1'b0;
  logic                       reset;
  logic [num_lanes-1:0]       in_valid;
  logic [num_lanes-1:0][31:0] in_inst;
  logic [num_lanes-1:0][63:0] in_npc, in_rega, in_regb;
  logic [num_lanes-1:0]       out_valid, out_illegal;
  logic [num_lanes-1:0][63:0] out_result;
  logic [num_lanes-1:0][4:0]  out_dest;
  logic                       redirect_valid, out_halt;
  logic [63:0]                redirect_pc;
  int                         errors = 0;

  // expected outputs of one bundle
  typedef struct {
    string                      name;
    logic [num_lanes-1:0]       valid;
    logic [num_lanes-1:0]       ill;
    logic [num_lanes-1:0]       chk;       // slots with a defined result and dest
    logic [num_lanes-1:0][63:0] result;
    logic [num_lanes-1:0][4:0]  dest;
    logic                       redir;
    logic                       halt;
    logic [63:0]                pc;
  } exp_t;

  exp_t exp_q [$];                         // oldest bundle in front

  // every alu function, as opcode group and function code
  logic [5:0] grp_tab [n_funcs] = '{op_inta, op_inta, op_inta, op_inta, op_inta, op_inta,
                                    op_inta, op_intl, op_intl, op_intl, op_intl, op_intl,
                                    op_intl, op_ints, op_ints, op_ints, op_intm};
  logic [6:0] fn_tab [n_funcs] = '{fn_addq, fn_subq, fn_cmpult, fn_cmpeq, fn_cmpule,
                                   fn_cmplt, fn_cmple, fn_and, fn_bic, fn_bis, fn_ornot,
                                   fn_xor, fn_eqv, fn_srl, fn_sll, fn_sra, fn_mulq};

  ex_cluster dut_i (.*);

  always #2 clock = ~clock;               // 4 ns period

  initial begin : watchdog
    #(n_total * 4 + 100);
    $display("watchdog expired, the last bundle never drained");
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model, alpha integer semantics
  //////////////////////////////////////////////////////////////////////
  task automatic model_slot(input logic [31:0] w, input logic [63:0] npc, a, b,
                            output logic [63:0] res, output logic [4:0] dest,
                            output logic take, hlt, ill);
    logic [63:0] bv;
    logic [5:0]  sh;
    logic        c;
    bv   = w[12] ? 64'(w[20:13]) : b;      // literal form uses 8-bit zext
    sh   = bv[5:0];
    res  = '0;
    dest = w[4:0];                          // rc
    take = 1'b0;
    hlt  = 1'b0;
    ill  = 1'b0;
    c    = 1'b0;
    case (w[31:26])
      op_inta: case (w[11:5])
        fn_addq:   res = a + bv;
        fn_subq:   res = a - bv;
        fn_cmpult: res = 64'(a < bv);
        fn_cmpeq:  res = 64'(a == bv);
        fn_cmpule: res = 64'(a <= bv);
        fn_cmplt:  res = 64'($signed(a) < $signed(bv));
        fn_cmple:  res = 64'($signed(a) <= $signed(bv));
        default:   ill = 1'b1;
      endcase
      op_intl: case (w[11:5])
        fn_and:   res = a & bv;
        fn_bic:   res = a & ~bv;
        fn_bis:   res = a | bv;
        fn_ornot: res = a | ~bv;
        fn_xor:   res = a ^ bv;
        fn_eqv:   res = ~(a ^ bv);
        default:  ill = 1'b1;
      endcase
      op_ints: case (w[11:5])
        fn_srl:  res = a >> sh;
        fn_sll:  res = a << sh;
        fn_sra:  res = $signed(a) >>> sh;
        default: ill = 1'b1;
      endcase
      op_intm: begin
        if (w[11:5] == fn_mulq) res = a * bv;   // low half of product
        else ill = 1'b1;
      end
      op_lda: begin
        res  = a + 64'($signed(w[15:0]));
        dest = w[25:21];                    // ra
      end
      op_call_pal: begin
        if (w[25:0] == 26'd0) hlt = 1'b1;
        else ill = 1'b1;
      end
      op_br:   take = 1'b1;
      6'h38:   c = ~a[0];                   // blbc
      6'h39:   c = a == 64'd0;              // beq
      6'h3a:   c = $signed(a) < 64'sd0;     // blt
      6'h3b:   c = $signed(a) <= 64'sd0;    // ble
      6'h3c:   c = a[0];                    // blbs
      6'h3d:   c = a != 64'd0;              // bne
      6'h3e:   c = $signed(a) >= 64'sd0;    // bge
      6'h3f:   c = $signed(a) > 64'sd0;     // bgt
      default: ill = 1'b1;
    endcase
    if (w[31:26] == op_br || w[31:29] == 3'b111) begin
      res  = npc + 64'($signed(w[20:0])) * 4;   // target from word displacement
      dest = zero_reg;
      take = take | c;
    end
  endtask

  task automatic expect_eq(string name, string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic compare_outputs(exp_t e);
    expect_eq(e.name, "out_valid", e.valid, out_valid);
    expect_eq(e.name, "out_illegal", e.ill, out_illegal);
    expect_eq(e.name, "redirect_valid", e.redir, redirect_valid);
    expect_eq(e.name, "out_halt", e.halt, out_halt);
    if (e.redir) expect_eq(e.name, "redirect_pc", e.pc, redirect_pc);
    for (int s = 0; s < num_lanes; s++) begin
      if (e.valid[s] && e.chk[s]) begin
        expect_eq(e.name, $sformatf("out_result[%0d]", s), e.result[s], out_result[s]);
        expect_eq(e.name, $sformatf("out_dest[%0d]", s), e.dest[s], out_dest[s]);
      end
    end
  endtask

  // drive one bundle, model it, and check the bundle that leaves now
  task automatic send_bundle(string name, logic [num_lanes-1:0] vld,
                             logic [num_lanes-1:0][31:0] inst,
                             logic [num_lanes-1:0][63:0] npc, a, b);
    exp_t        e;
    logic [63:0] r;
    logic [4:0]  d;
    logic        t, h, il;
    logic        done;                      // oldest redirect or halt seen
    e.name  = name;
    e.valid = '0;
    e.ill   = '0;
    e.redir = 1'b0;
    e.halt  = 1'b0;
    e.pc    = '0;
    done    = 1'b0;
    for (int s = 0; s < num_lanes; s++) begin
      model_slot(inst[s], npc[s], a[s], b[s], r, d, t, h, il);
      e.result[s] = r;
      e.dest[s]   = d;
      e.chk[s]    = !(h || il);
      if (vld[s] && !done) begin            // younger slots squashed
        e.valid[s] = 1'b1;
        e.ill[s]   = il;
        if (t || h) begin
          done    = 1'b1;
          e.redir = t;
          e.halt  = h;
          e.pc    = r;
        end
      end
    end
    in_valid = vld;
    in_inst  = inst;
    in_npc   = npc;
    in_rega  = a;
    in_regb  = b;
    exp_q.push_back(e);
    if (exp_q.size() > 3) compare_outputs(exp_q.pop_front());  // three in flight
    @(posedge clock);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [63:0] rand_val();
    case ($urandom_range(3))
      0:       return 64'($urandom_range(15));           // small, zero included
      1:       return -64'($urandom_range(1, 16));       // small negative
      2:       return {1'b1, 31'($urandom), 32'($urandom)};
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic logic [31:0] operate(logic [5:0] op, logic [6:0] fn);
    logic [31:0] w;
    w = {op, 5'($urandom), 5'($urandom), 3'b000, 1'b0, fn, 5'($urandom)};
    if ($urandom_range(1) == 1) w[20:12] = {8'($urandom), 1'b1};   // literal form
    return w;
  endfunction

  function automatic logic [31:0] branch(logic [5:0] op, logic [20:0] disp);
    return {op, 5'($urandom), disp};
  endfunction

  task automatic rand_operands(output logic [num_lanes-1:0][63:0] p, a, b);
    for (int s = 0; s < num_lanes; s++) begin
      p[s] = {32'($urandom), 30'($urandom), 2'b00};   // word aligned npc
      a[s] = rand_val();
      b[s] = rand_val();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence, one bundle per cycle
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [num_lanes-1:0][31:0] w;
    logic [num_lanes-1:0][63:0] p, a, b;
    int unsigned                k;
    int unsigned                asrt;
    void'($urandom(32'hdbd3));
    reset    = 1'b1;
    in_valid = '0;
    in_inst  = '0;
    in_npc   = '0;
    in_rega  = '0;
    in_regb  = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int n = 0; n < n_rand; n++) begin      // walks every alu function
      rand_operands(p, a, b);
      for (int s = 0; s < num_lanes; s++) begin
        k    = (n * num_lanes + s) % n_funcs;
        w[s] = operate(grp_tab[k], fn_tab[k]);
      end
      send_bundle("operate", (n % 4 == 0) ? 4'($urandom) : 4'hf, w, p, a, b);
    end

    for (int n = 0; n < 6; n++) begin           // even slots positive disp
      rand_operands(p, a, b);
      for (int s = 0; s < num_lanes; s++)
        w[s] = {op_lda, 5'($urandom), 5'($urandom), 1'(s), 15'($urandom)};
      send_bundle("lda", 4'hf, w, p, a, b);
    end

    for (int op = 0; op < 8; op++) begin
      for (int c = 0; c < 4; c++) begin
        rand_operands(p, a, b);
        w[0] = branch(op_bcc_lo + 6'(op), 21'($urandom));
        case (c)
          0:       a[0] = 64'd0;
          1:       a[0] = {1'b1, 63'($urandom)};
          2:       a[0] = {1'b0, 62'($urandom), 1'b1};       // positive odd
          default: a[0] = {1'b0, 61'($urandom), 2'b10};      // positive even
        endcase
        for (int s = 1; s < num_lanes; s++) w[s] = operate(op_inta, fn_addq);
        send_bundle("cond_branch", 4'hf, w, p, a, b);
      end
    end

    for (int pos = 0; pos < num_lanes; pos++) begin
      for (int kind = 0; kind < 3; kind++) begin
        rand_operands(p, a, b);
        for (int s = 0; s < num_lanes; s++)   // younger slots hold taken br
          w[s] = (s > pos) ? branch(op_br, 21'($urandom)) : operate(op_intl, fn_xor);
        if (pos > 0) begin                    // older bne that falls through
          w[pos-1] = branch(6'h3d, 21'($urandom));
          a[pos-1] = 64'd0;
        end
        case (kind)
          0: w[pos] = branch(op_br, 21'($urandom));
          1: begin
            w[pos] = branch(6'h39, 21'($urandom));   // beq on zero
            a[pos] = 64'd0;
          end
          default: w[pos] = 32'd0;            // halt
        endcase
        send_bundle("squash", 4'hf, w, p, a, b);
      end
    end

    for (int n = 0; n < 8; n++) begin         // opcodes 0x16 to 0x1d, all unsupported
      rand_operands(p, a, b);
      for (int s = 0; s < num_lanes; s++) w[s] = operate(op_inta, fn_subq);
      w[n % num_lanes] = {6'h16 + 6'(n), 26'($urandom)};
      if (n == 7) w[0] = {op_call_pal, 26'h83};
      send_bundle("illegal", 4'hf, w, p, a, b);
    end

    repeat (3) send_bundle("drain", '0, w, p, a, b);

    asrt = dut_i.chk_i.fail_count;
    $display("errors: %0d value checks, %0d assertions", errors, asrt);
    if (errors == 0 && asrt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/alu.sv
// 64-bit integer alu
`timescale 1ns/10ps

module alu import ex_pkg::*; (
  input  logic [63:0] opa,
  input  logic [63:0] opb,
  input  alu_func_t   func,
  output logic [63:0] result
);

  logic [5:0]  shamt;      // shifts use the low six bits of b
  logic [63:0] srl_val;
  logic [63:0] sra_fill;   // sign bits shifted in from the top
  logic        lt_s;       // signed a < b
  logic        lt_u;
  logic        eq;

  assign shamt   = opb[5:0];
  assign srl_val = opa >> shamt;
  assign sra_fill = opa[63] ? ~(64'hffff_ffff_ffff_ffff >> shamt) : 64'd0;

  assign lt_u = opa < opb;
  assign eq   = opa == opb;
  // same sign: unsigned order holds, else the negative one is smaller
  assign lt_s = (opa[63] == opb[63]) ? lt_u : opa[63];

  always_comb begin
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = srl_val;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = srl_val | sra_fill;
      alu_mulq:   result = opa * opb;            // low 64 bits of product
      alu_cmpult: result = {63'd0, lt_u};
      alu_cmpeq:  result = {63'd0, eq};
      alu_cmpule: result = {63'd0, lt_u | eq};
      alu_cmplt:  result = {63'd0, lt_s};
      alu_cmple:  result = {63'd0, lt_s | eq};
      default:    result = 64'd0;                // unused encodings
    endcase
  end

endmodule

// File: verilog/branch_resolve.sv
// bundle branch resolver
`timescale 1ns/10ps

module branch_resolve import ex_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  lane_result_if.res                 res [num_lanes],
  output logic [num_lanes-1:0]       out_valid,
  output logic [num_lanes-1:0][63:0] out_result,
  output logic [num_lanes-1:0][4:0]  out_dest,
  output logic [num_lanes-1:0]       out_illegal,
  output logic                       redirect_valid,
  output logic [63:0]                redirect_pc,
  output logic                       out_halt
);

  logic [num_lanes-1:0]       vld, tkb, hlt, ill;
  logic [num_lanes-1:0][63:0] rslt, npc;
  logic [num_lanes-1:0][4:0]  dst;
  logic [num_lanes-1:0]       keep;     // slots that survive the squash
  logic                       redir_d;
  logic                       halt_d;
  logic [63:0]                pc_d;

  // flatten the lane links so the scan can index them
  for (genvar s = 0; s < num_lanes; s++) begin : g_unpack
    assign vld[s]  = res[s].valid;
    assign tkb[s]  = res[s].take_branch;
    assign hlt[s]  = res[s].halt;
    assign ill[s]  = res[s].illegal;
    assign rslt[s] = res[s].result;
    assign npc[s]  = res[s].npc;
    assign dst[s]  = res[s].dest;
  end

  //////////////////////////////////////////////////////////////////////
  // priority scan, slot 0 is oldest
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    logic found;                        // oldest branch or halt already seen
    found   = 1'b0;
    keep    = '0;
    redir_d = 1'b0;
    halt_d  = 1'b0;
    pc_d    = 64'd0;
    for (int s = 0; s < num_lanes; s++) begin
      if (!found && vld[s]) begin
        keep[s] = 1'b1;
        if (tkb[s] || hlt[s]) begin
          found   = 1'b1;
          redir_d = tkb[s];
          halt_d  = hlt[s];
          pc_d    = tkb[s] ? rslt[s] : npc[s];  // halt leaves its resume pc
        end
      end
    end
  end

  // stage 3 register, cluster outputs
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid      <= '0;
      out_illegal    <= '0;
      redirect_valid <= 1'b0;
      out_halt       <= 1'b0;
    end else begin
      out_valid      <= keep;
      out_illegal    <= keep & ill;
      redirect_valid <= redir_d;
      out_halt       <= halt_d;
    end
    out_result  <= rslt;
    out_dest    <= dst;
    redirect_pc <= pc_d;
  end

endmodule

// File: verilog/ex_cluster.sv
// four-slot integer execute cluster
`timescale 1ns/10ps

module ex_cluster import ex_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  // bundle in, slot 0 oldest
  input  logic [num_lanes-1:0]       in_valid,
  input  logic [num_lanes-1:0][31:0] in_inst,
  input  logic [num_lanes-1:0][63:0] in_npc,
  input  logic [num_lanes-1:0][63:0] in_rega,
  input  logic [num_lanes-1:0][63:0] in_regb,
  // results, three cycles later
  output logic [num_lanes-1:0]       out_valid,
  output logic [num_lanes-1:0][63:0] out_result,
  output logic [num_lanes-1:0][4:0]  out_dest,
  output logic [num_lanes-1:0]       out_illegal,
  output logic                       redirect_valid,
  output logic [63:0]                redirect_pc,
  output logic                       out_halt
);

  lane_issue_if  iss_if [num_lanes] ();   // decoder to lanes
  lane_result_if res_if [num_lanes] ();   // lanes to resolver

  //////////////////////////////////////////////////////////////////////
  // stage 1, decode
  //////////////////////////////////////////////////////////////////////
  issue_decode u_decode (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_inst  (in_inst),
    .in_npc   (in_npc),
    .in_rega  (in_rega),
    .in_regb  (in_regb),
    .iss      (iss_if)
  );

  // stage 2, one lane per slot
  for (genvar g = 0; g < num_lanes; g++) begin : g_lane
    ex_lane u_lane (
      .clock (clock),
      .reset (reset),
      .iss   (iss_if[g]),
      .res   (res_if[g])
    );
  end

  // stage 3, squash and redirect
  branch_resolve u_resolve (
    .clock          (clock),
    .reset          (reset),
    .res            (res_if),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .out_dest       (out_dest),
    .out_illegal    (out_illegal),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .out_halt       (out_halt)
  );

endmodule

// File: verilog/ex_lane.sv
// integer execute lane
`timescale 1ns/10ps

module ex_lane import ex_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  lane_issue_if.lane  iss,
  lane_result_if.lane res
);

  logic [63:0] mem_disp;   // sext 16-bit memory displacement
  logic [63:0] br_disp;    // sext 21-bit word displacement, in bytes
  logic [63:0] alu_imm;    // zero-extended operate literal
  logic [63:0] opa_mux, opb_mux;
  logic [63:0] alu_out;
  logic [2:0]  br_func;    // inst[28:26]
  logic        cond;
  logic        take;

  //////////////////////////////////////////////////////////////////////
  // immediates and operand muxes
  //////////////////////////////////////////////////////////////////////

  assign mem_disp = {{48{iss.inst.br.disp[15]}}, iss.inst.br.disp[15:0]};
  assign br_disp  = {{41{iss.inst.br.disp[20]}}, iss.inst.br.disp, 2'b00};
  assign alu_imm  = {56'd0, iss.inst.opr.lit};

  always_comb begin
    case (iss.opa_sel)
      opa_is_rega:     opa_mux = iss.rega;
      opa_is_mem_disp: opa_mux = mem_disp;
      opa_is_npc:      opa_mux = iss.npc;
      default:         opa_mux = ~64'h3;     // opa_is_not3
    endcase
  end

  always_comb begin
    case (iss.opb_sel)
      opb_is_regb:    opb_mux = iss.regb;
      opb_is_alu_imm: opb_mux = alu_imm;
      opb_is_br_disp: opb_mux = br_disp;
      default:        opb_mux = 64'd0;       // encoding 3 is never decoded
    endcase
  end

  alu u_alu (
    .opa    (opa_mux),
    .opb    (opb_mux),
    .func   (iss.alu_func),
    .result (alu_out)
  );

  // branch condition, always tested on the a register value
  assign br_func = iss.inst.br.opcode[2:0];

  always_comb begin
    case (br_func[1:0])
      2'b00:   cond = ~iss.rega[0];                     // low bit clear
      2'b01:   cond = iss.rega == 64'd0;                // zero
      2'b10:   cond = iss.rega[63];                     // negative
      default: cond = iss.rega[63] | (iss.rega == 64'd0);  // not positive
    endcase
    if (br_func[2]) cond = ~cond;                       // lbs, ne, ge, gt
  end

  assign take = iss.valid & (iss.uncond_br | (iss.cond_br & cond));

  // stage 2 register, flags only count for a valid slot
  always_ff @(posedge clock) begin
    if (reset) begin
      res.valid       <= 1'b0;
      res.take_branch <= 1'b0;
      res.halt        <= 1'b0;
      res.illegal     <= 1'b0;
    end else begin
      res.valid       <= iss.valid;
      res.take_branch <= take;
      res.halt        <= iss.valid & iss.halt;
      res.illegal     <= iss.valid & iss.illegal;
    end
    res.result <= alu_out;
    res.npc    <= iss.npc;
    res.dest   <= iss.dest;
  end

endmodule

// File: verilog/ex_pkg.sv
// execute cluster shared definitions
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // cluster shape
  //////////////////////////////////////////////////////////////////////

  localparam int num_lanes = 4;              // slots per bundle, one lane each

  localparam logic [4:0] zero_reg = 5'd31;   // r31 as destination means no write

  //////////////////////////////////////////////////////////////////////
  // opcodes, bits 31:26
  //////////////////////////////////////////////////////////////////////

  localparam logic [5:0] op_call_pal = 6'h00;  // only halt (function 0) is kept
  localparam logic [5:0] op_lda      = 6'h08;
  localparam logic [5:0] op_inta     = 6'h10;  // add, sub, compares
  localparam logic [5:0] op_intl     = 6'h11;  // logicals
  localparam logic [5:0] op_ints     = 6'h12;  // shifts
  localparam logic [5:0] op_intm     = 6'h13;  // multiply
  localparam logic [5:0] op_br       = 6'h30;
  localparam logic [5:0] op_bcc_lo   = 6'h38;  // first conditional branch (blbc)
  localparam logic [5:0] op_bcc_hi   = 6'h3f;  // last conditional branch (bgt)

  // operate function codes, bits 11:5, meaning depends on the opcode group
  localparam logic [6:0] fn_addq   = 7'h20;  // inta
  localparam logic [6:0] fn_subq   = 7'h29;
  localparam logic [6:0] fn_cmpult = 7'h1d;
  localparam logic [6:0] fn_cmpeq  = 7'h2d;
  localparam logic [6:0] fn_cmpule = 7'h3d;
  localparam logic [6:0] fn_cmplt  = 7'h4d;
  localparam logic [6:0] fn_cmple  = 7'h6d;
  localparam logic [6:0] fn_and    = 7'h00;  // intl
  localparam logic [6:0] fn_bic    = 7'h08;
  localparam logic [6:0] fn_bis    = 7'h20;
  localparam logic [6:0] fn_ornot  = 7'h28;
  localparam logic [6:0] fn_xor    = 7'h40;
  localparam logic [6:0] fn_eqv    = 7'h48;
  localparam logic [6:0] fn_srl    = 7'h34;  // ints
  localparam logic [6:0] fn_sll    = 7'h39;
  localparam logic [6:0] fn_sra    = 7'h3c;
  localparam logic [6:0] fn_mulq   = 7'h20;  // intm

  //////////////////////////////////////////////////////////////////////
  // control encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    alu_addq,
    alu_subq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_mulq,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_t;

  typedef enum logic [1:0] {
    opa_is_rega,
    opa_is_mem_disp,
    opa_is_npc,
    opa_is_not3
  } opa_sel_t;

  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_alu_imm,
    opb_is_br_disp
  } opb_sel_t;

  // operate format; in register form lit[7:3] is rb and lit[2:0] is zero
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [7:0] lit;       // zero-extended literal when lit_flag is set
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } opr_fmt_t;

  // branch and memory format, memory displacement is disp[15:0]
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;
  } br_fmt_t;

  typedef union packed {
    opr_fmt_t opr;
    br_fmt_t  br;
  } alpha_inst_t;

endpackage

// File: verilog/issue_decode.sv
// bundle decoder
`timescale 1ns/10ps

module issue_decode import ex_pkg::*; (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [num_lanes-1:0]        in_valid,
  input  logic [num_lanes-1:0][31:0]  in_inst,
  input  logic [num_lanes-1:0][63:0]  in_npc,
  input  logic [num_lanes-1:0][63:0]  in_rega,
  input  logic [num_lanes-1:0][63:0]  in_regb,
  lane_issue_if.dec                   iss [num_lanes]
);

  for (genvar i = 0; i < num_lanes; i++) begin : g_slot
    alpha_inst_t inst;
    alu_func_t   func_d;
    opa_sel_t    opa_d;
    opb_sel_t    opb_d;
    logic        cond_d, uncond_d, halt_d, ill_d;
    logic [4:0]  dest_d;
    logic [63:0] b_val;                          // value sent as operand b

    assign inst = in_inst[i];

    ////////////////////////////////////////////////////////////////////
    // opcode and function decode
    ////////////////////////////////////////////////////////////////////
    always_comb begin
      func_d   = alu_addq;
      opa_d    = opa_is_rega;
      opb_d    = inst.opr.lit_flag ? opb_is_alu_imm : opb_is_regb;
      cond_d   = 1'b0;
      uncond_d = 1'b0;
      halt_d   = 1'b0;
      ill_d    = 1'b0;
      dest_d   = inst.opr.rc;                    // operate ops write rc
      b_val    = in_regb[i];
      case (inst.opr.opcode)
        op_inta: begin
          case (inst.opr.func)
            fn_addq:   func_d = alu_addq;
            fn_subq:   func_d = alu_subq;
            fn_cmpult: func_d = alu_cmpult;
            fn_cmpeq:  func_d = alu_cmpeq;
            fn_cmpule: func_d = alu_cmpule;
            fn_cmplt:  func_d = alu_cmplt;
            fn_cmple:  func_d = alu_cmple;
            default:   ill_d  = 1'b1;
          endcase
        end
        op_intl: begin
          case (inst.opr.func)
            fn_and:   func_d = alu_and;
            fn_bic:   func_d = alu_bic;
            fn_bis:   func_d = alu_bis;
            fn_ornot: func_d = alu_ornot;
            fn_xor:   func_d = alu_xor;
            fn_eqv:   func_d = alu_eqv;
            default:  ill_d  = 1'b1;
          endcase
        end
        op_ints: begin
          case (inst.opr.func)
            fn_srl:  func_d = alu_srl;
            fn_sll:  func_d = alu_sll;
            fn_sra:  func_d = alu_sra;
            default: ill_d  = 1'b1;
          endcase
        end
        op_intm: begin
          if (inst.opr.func == fn_mulq) func_d = alu_mulq;
          else ill_d = 1'b1;
        end
        op_lda: begin                            // ra = rega + sext(disp)
          opa_d  = opa_is_mem_disp;
          opb_d  = opb_is_regb;
          b_val  = in_rega[i];                   // base rides on the b operand
          dest_d = inst.br.ra;
        end
        op_br: begin                             // target = npc + 4*disp
          opa_d    = opa_is_npc;
          opb_d    = opb_is_br_disp;
          uncond_d = 1'b1;
        end
        op_call_pal: begin
          if (inst.br.ra == 5'd0 && inst.br.disp == 21'd0) halt_d = 1'b1;
          else ill_d = 1'b1;                     // other pal calls unsupported
        end
        default: begin
          if (inst.br.opcode inside {[op_bcc_lo:op_bcc_hi]}) begin
            opa_d  = opa_is_npc;
            opb_d  = opb_is_br_disp;
            cond_d = 1'b1;
          end else begin
            ill_d = 1'b1;
          end
        end
      endcase
      // branches, halt and illegal slots never write a register
      if (cond_d || uncond_d || halt_d || ill_d) dest_d = zero_reg;
    end

    // stage 1 register, whole packet moves together
    always_ff @(posedge clock) begin
      if (reset) iss[i].valid <= 1'b0;
      else       iss[i].valid <= in_valid[i];
      iss[i].npc       <= in_npc[i];
      iss[i].inst      <= inst;
      iss[i].rega      <= in_rega[i];
      iss[i].regb      <= b_val;
      iss[i].opa_sel   <= opa_d;
      iss[i].opb_sel   <= opb_d;
      iss[i].alu_func  <= func_d;
      iss[i].cond_br   <= cond_d;
      iss[i].uncond_br <= uncond_d;
      iss[i].halt      <= halt_d;
      iss[i].illegal   <= ill_d;
      iss[i].dest      <= dest_d;
    end
  end

endmodule

// File: verilog/lane_if.sv
// decoder, lane and resolver links
`timescale 1ns/10ps

// decoded packet, decoder to one lane
interface lane_issue_if import ex_pkg::*;;
  logic        valid;     // slot holds an instruction
  logic [63:0] npc;       // pc of the next instruction
  alpha_inst_t inst;      // raw word, lane takes immediates from it
  logic [63:0] rega;      // operand a value
  logic [63:0] regb;      // operand b value
  opa_sel_t    opa_sel;
  opb_sel_t    opb_sel;
  alu_func_t   alu_func;
  logic        cond_br;   // conditional branch, taken per brcond
  logic        uncond_br; // br, always taken
  logic        halt;
  logic        illegal;
  logic [4:0]  dest;      // zero_reg when nothing is written

  modport dec (output valid, npc, inst, rega, regb, opa_sel, opb_sel, alu_func,
               cond_br, uncond_br, halt, illegal, dest);
  modport lane (input valid, npc, inst, rega, regb, opa_sel, opb_sel, alu_func,
                cond_br, uncond_br, halt, illegal, dest);
endinterface

// executed slot, lane to resolver
interface lane_result_if;
  logic        valid;
  logic [63:0] result;      // alu output, branch target for branches
  logic [63:0] npc;
  logic [4:0]  dest;
  logic        take_branch;
  logic        halt;
  logic        illegal;

  modport lane (output valid, result, npc, dest, take_branch, halt, illegal);
  modport res (input valid, result, npc, dest, take_branch, halt, illegal);
endinterface
